//--- list.f
fetch_pkg.sv
btb_predictor.sv
fetch_unit.sv
fetch_buffer.sv
reg_file.sv
decode_resolve.sv
fetch_top.sv
tb_fetch_top.sv

//--- Bender.yml
package:
  name: fetch_top

sources:
  - fetch_pkg.sv
  - btb_predictor.sv
  - fetch_unit.sv
  - fetch_buffer.sv
  - reg_file.sv
  - decode_resolve.sv
  - fetch_top.sv
  - target: test
    files:
      - tb_fetch_top.sv

//--- tb_fetch_top.sv
`timescale 1ns/100ps

module tb_fetch_top;

    // Small BTB so that jumps can share an index
    localparam int BTB_IW = 2;
    localparam fetch_pkg::word_t NOP = 32'h0000_0013;

    logic                clk = 1'b0;
    logic                rst;
    logic                stall;
    fetch_pkg::word_t    fetch_instr;
    fetch_pkg::reg_wr_t  wb;
    fetch_pkg::word_t    fetch_pc;
    fetch_pkg::issue_t   issue;
    logic                mispredict;

    fetch_pkg::word_t imem [256];
    fetch_pkg::word_t m_regs [32];
    fetch_pkg::word_t m_pc;
    logic             m_valid [2**BTB_IW];
    fetch_pkg::word_t m_tag [2**BTB_IW];
    fetch_pkg::word_t m_tgt [2**BTB_IW];
    int               m_mis;
    int               dut_mis;
    int               seen;
    int               errors;
    int               checks;
    int               test_err0;
    integer           seed = 83379;

    always #5 clk = ~clk;

    // Combinational instruction memory
    assign fetch_instr = imem[fetch_pc[9:2]];

    fetch_top #(
        .BTB_INDEX_WIDTH (BTB_IW)
    ) dut (
        .clk_i         (clk),
        .rst_i         (rst),
        .stall_i       (stall),
        .fetch_instr_i (fetch_instr),
        .wb_i          (wb),
        .fetch_pc_o    (fetch_pc),
        .issue_o       (issue),
        .mispredict_o  (mispredict)
    );

    function automatic fetch_pkg::word_t enc_jal(input int off);
        logic [20:0] o;
        o = off;
        return {o[20], o[10:1], o[11], o[19:12], 5'd0, fetch_pkg::OPC_JAL};
    endfunction

    function automatic fetch_pkg::word_t enc_jalr(input logic [4:0] rs1, input int imm);
        logic [11:0] o;
        o = imm;
        return {o, rs1, 3'b000, 5'd0, fetch_pkg::OPC_JALR};
    endfunction

    function automatic fetch_pkg::word_t enc_branch(input logic [2:0] f3, input logic [4:0] rs1,
                                                    input logic [4:0] rs2, input int off);
        logic [12:0] o;
        o = off;
        return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], fetch_pkg::OPC_BRANCH};
    endfunction

    // Architectural stepper with its own always-taken BTB
    task automatic step_model(output fetch_pkg::issue_t exp);
        fetch_pkg::word_t ins;
        fetch_pkg::word_t a;
        fetch_pkg::word_t b;
        fetch_pkg::word_t tgt;
        fetch_pkg::word_t tag;
        logic             taken;
        logic             hit;
        int               idx;
        ins = imem[m_pc[9:2]];
        a = m_regs[ins[19:15]];
        b = m_regs[ins[24:20]];
        taken = 1'b0;
        tgt = m_pc;
        case (ins[6:0])
            fetch_pkg::OPC_JAL: begin
                taken = 1'b1;
                tgt = m_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            fetch_pkg::OPC_JALR: begin
                taken = 1'b1;
                tgt = a + {{20{ins[31]}}, ins[31:20]};
            end
            fetch_pkg::OPC_BRANCH: begin
                tgt = m_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                case (ins[14:12])
                    fetch_pkg::F3_BEQ:  taken = (a == b);
                    fetch_pkg::F3_BNE:  taken = (a != b);
                    fetch_pkg::F3_BLT:  taken = ($signed(a) < $signed(b));
                    fetch_pkg::F3_BGE:  taken = ($signed(a) >= $signed(b));
                    fetch_pkg::F3_BLTU: taken = (a < b);
                    fetch_pkg::F3_BGEU: taken = (a >= b);
                    default:            taken = 1'b0;
                endcase
            end
            default: ;
        endcase
        idx = m_pc[BTB_IW+1:2];
        tag = m_pc >> (BTB_IW + 2);
        hit = m_valid[idx] && (m_tag[idx] == tag);
        if ((hit != taken) || (hit && taken && (m_tgt[idx] != tgt))) begin
            m_mis++;
            // Only taken jumps allocate
            if (taken) begin
                m_valid[idx] = 1'b1;
                m_tag[idx] = tag;
                m_tgt[idx] = tgt;
            end
        end
        exp = {1'b1, m_pc, ins};
        m_pc = taken ? tgt : m_pc + 32'd4;
    endtask

    task automatic check_issue(input fetch_pkg::issue_t got, input fetch_pkg::issue_t exp);
        checks++;
        if ((got.valid !== exp.valid) ||
            (exp.valid && ((got.pc !== exp.pc) || (got.instr !== exp.instr)))) begin
            errors++;
            $display(
                "[ERROR] %0t: issue valid=%0b pc=%h instr=%h, expected valid=%0b pc=%h instr=%h",
                $time, got.valid, got.pc, got.instr, exp.valid, exp.pc, exp.instr);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_pc(input fetch_pkg::word_t got, input fetch_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: fetch pc is %h, expected %h", $time, got, exp);
        end
    endtask

    // Drive after the rising edge and sample at the falling edge
    task automatic cycle(input logic stall_val, input fetch_pkg::reg_wr_t wb_val);
        fetch_pkg::issue_t exp;
        @(posedge clk);
        #1;
        stall = stall_val;
        wb = wb_val;
        @(negedge clk);
        if (mispredict === 1'b1) begin
            dut_mis++;
        end
        if (issue.valid === 1'b1) begin
            step_model(exp);
            check_issue(issue, exp);
            seen++;
        end
    endtask

    task automatic write_reg(input fetch_pkg::reg_idx_t rd, input fetch_pkg::word_t value);
        fetch_pkg::reg_wr_t w;
        w.en = 1'b1;
        w.addr = rd;
        w.data = value;
        cycle(1'b1, w);
        if (rd != '0) begin
            m_regs[rd] = value;
        end
    endtask

    task automatic run(input int n, input bit rand_stall);
        int   start;
        int   cyc;
        logic s;
        start = seen;
        cyc = 0;
        while (seen - start < n) begin
            if (cyc == 8 * n + 40) begin
                $display("Timeout: %0d of %0d instructions issued within %0d cycles",
                         seen - start, n, cyc);
                $display("*** TEST FAILED ***");
                $finish;
            end else begin
                s = rand_stall ? ($random(seed) % 4 == 0) : 1'b0;
                cycle(s, '0);
                cyc++;
            end
        end
    endtask

    task automatic apply_reset;
        @(posedge clk);
        #1;
        rst = 1'b1;
        stall = 1'b0;
        wb = '0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        m_pc = fetch_pkg::RESET_PC;
        m_mis = 0;
        dut_mis = 0;
        seen = 0;
        test_err0 = errors;
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        for (int i = 0; i < 2**BTB_IW; i++) begin
            m_valid[i] = 1'b0;
        end
    endtask

    task automatic load_nops;
        for (int i = 0; i < 256; i++) begin
            imem[i] = NOP;
        end
    endtask

    task automatic report(input string name);
        $display("%s: %0d errors", name, errors - test_err0);
    endtask

    task automatic test_reset;
        fetch_pkg::issue_t idle;
        idle = '0;
        load_nops();
        apply_reset();
        @(negedge clk);
        check_pc(fetch_pc, fetch_pkg::RESET_PC);
        check_issue(issue, idle);
        check_count(int'(mispredict), 0, "mispredict level");
        report("reset state");
    endtask

    task automatic test_straight;
        load_nops();
        apply_reset();
        run(40, 1'b1);
        check_count(dut_mis, m_mis, "mispredict total");
        report("straight line with stalls");
    endtask

    task automatic test_jal_loop;
        load_nops();
        imem[1] = enc_jal(8);
        imem[4] = enc_jal(-16);
        apply_reset();
        run(4, 1'b0);
        check_count(dut_mis, m_mis, "first pass mispredicts");
        run(16, 1'b0);
        check_count(dut_mis, m_mis, "mispredict total");
        report("jal loop learning");
    endtask

    task automatic test_branch(input logic [2:0] f3);
        fetch_pkg::word_t a;
        a = $random(seed);
        load_nops();
        imem[0] = enc_branch(f3, 5'd1, 5'd2, 12);
        imem[3] = enc_jal(-12);
        apply_reset();
        write_reg(5'd1, a);
        write_reg(5'd2, ($random(seed) % 2 == 0) ? a : fetch_pkg::word_t'($random(seed)));
        run(12, 1'b0);
        check_count(dut_mis, m_mis, "mispredict total");
        $display("branch funct3 %b: %0d errors", f3, errors - test_err0);
    endtask

    task automatic test_not_taken;
        load_nops();
        imem[2] = enc_branch(fetch_pkg::F3_BEQ, 5'd1, 5'd2, -8);
        apply_reset();
        run(9, 1'b0);
        write_reg(5'd1, 32'd5);
        run(6, 1'b0);
        check_count(dut_mis, m_mis, "mispredict total");
        report("trained branch not taken");
    endtask

    // Jumps at 16, 32 and 48 all map to BTB index 0
    task automatic test_jalr_conflict;
        load_nops();
        imem[1] = enc_jalr(5'd5, 0);
        imem[4] = enc_jal(16);
        imem[8] = enc_jal(-32);
        imem[12] = enc_jal(-48);
        apply_reset();
        write_reg(5'd5, 32'd16);
        run(12, 1'b0);
        write_reg(5'd5, 32'd48);
        run(12, 1'b0);
        check_count(dut_mis, m_mis, "mispredict total");
        report("jalr and btb conflicts");
    endtask

    initial begin
        rst = 1'b1;
        stall = 1'b0;
        wb = '0;
        errors = 0;
        checks = 0;
        load_nops();
        test_reset();
        test_straight();
        test_jal_loop();
        test_branch(fetch_pkg::F3_BEQ);
        test_branch(fetch_pkg::F3_BNE);
        test_branch(fetch_pkg::F3_BLT);
        test_branch(fetch_pkg::F3_BGE);
        test_branch(fetch_pkg::F3_BLTU);
        test_branch(fetch_pkg::F3_BGEU);
        test_not_taken();
        test_jalr_conflict();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- fetch_top.sv
`timescale 1ns/100ps

module fetch_top #(
    parameter int BTB_INDEX_WIDTH = 6
) (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               stall_i,
    input  fetch_pkg::word_t   fetch_instr_i,
    input  fetch_pkg::reg_wr_t wb_i,
    output fetch_pkg::word_t   fetch_pc_o,
    output fetch_pkg::issue_t  issue_o,
    output logic               mispredict_o
);

    fetch_pkg::fetch_t   if_fetch;
    fetch_pkg::fetch_t   id_fetch;
    fetch_pkg::resolve_t ex_resolve;
    logic                flush;

    // IF stage with PC and BTB
    fetch_unit #(
        .BTB_INDEX_WIDTH (BTB_INDEX_WIDTH)
    ) u_fetch_unit (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .stall_i   (stall_i),
        .instr_i   (fetch_instr_i),
        .resolve_i (ex_resolve),
        .pc_o      (fetch_pc_o),
        .fetch_o   (if_fetch),
        .flush_o   (flush)
    );

    // IF/ID
    fetch_buffer u_fetch_buffer (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .stall_i (stall_i),
        .flush_i (flush),
        .fetch_i (if_fetch),
        .fetch_o (id_fetch)
    );

    // ID and ID/EX with branch resolution
    decode_resolve u_decode_resolve (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .stall_i   (stall_i),
        .flush_i   (flush),
        .fetch_i   (id_fetch),
        .wb_i      (wb_i),
        .resolve_o (ex_resolve),
        .issue_o   (issue_o)
    );

    assign mispredict_o = flush;

endmodule

//--- decode_resolve.sv
`timescale 1ns/100ps

module decode_resolve (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                stall_i,
    input  logic                flush_i,
    input  fetch_pkg::fetch_t   fetch_i,
    input  fetch_pkg::reg_wr_t  wb_i,
    output fetch_pkg::resolve_t resolve_o,
    output fetch_pkg::issue_t   issue_o
);

    // ID/EX payload
    typedef struct packed {
        logic             btb_hit;
        logic             is_uncond;
        logic             is_branch;
        logic             cmp_true;
        fetch_pkg::word_t pc;
        fetch_pkg::word_t instr;
        fetch_pkg::word_t target;
    } id_ex_t;

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    fetch_pkg::reg_idx_t rs1;
    fetch_pkg::reg_idx_t rs2;
    fetch_pkg::word_t    rd1;
    fetch_pkg::word_t    rd2;
    fetch_pkg::word_t    imm;
    fetch_pkg::word_t    base;
    logic                is_jal;
    logic                is_jalr;
    logic                is_branch;
    logic                cmp_true;
    id_ex_t              id_d;
    id_ex_t              ex_q;
    logic                ex_valid_q;
    logic                ex_taken;

    assign opcode = fetch_i.instr[6:0];
    assign funct3 = fetch_i.instr[14:12];
    assign rs1    = fetch_i.instr[19:15];
    assign rs2    = fetch_i.instr[24:20];

    assign is_jal    = (opcode == fetch_pkg::OPC_JAL);
    assign is_jalr   = (opcode == fetch_pkg::OPC_JALR);
    assign is_branch = (opcode == fetch_pkg::OPC_BRANCH);

    reg_file u_reg_file (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .rs1_i (rs1),
        .rs2_i (rs2),
        .wb_i  (wb_i),
        .rd1_o (rd1),
        .rd2_o (rd2)
    );

    // J, I or B immediate
    always_comb begin
        if (is_jal) begin
            imm = {{12{fetch_i.instr[31]}}, fetch_i.instr[19:12], fetch_i.instr[20],
                   fetch_i.instr[30:21], 1'b0};
        end else if (is_jalr) begin
            imm = {{21{fetch_i.instr[31]}}, fetch_i.instr[30:20]};
        end else begin
            imm = {{20{fetch_i.instr[31]}}, fetch_i.instr[7], fetch_i.instr[30:25],
                   fetch_i.instr[11:8], 1'b0};
        end
    end

    always_comb begin
        unique case (funct3)
            fetch_pkg::F3_BEQ:  cmp_true = (rd1 == rd2);
            fetch_pkg::F3_BNE:  cmp_true = (rd1 != rd2);
            fetch_pkg::F3_BLT:  cmp_true = ($signed(rd1) < $signed(rd2));
            fetch_pkg::F3_BGE:  cmp_true = ($signed(rd1) >= $signed(rd2));
            fetch_pkg::F3_BLTU: cmp_true = (rd1 < rd2);
            fetch_pkg::F3_BGEU: cmp_true = (rd1 >= rd2);
            default:            cmp_true = 1'b0;
        endcase
    end

    // JALR is register based, everything else PC relative
    assign base = is_jalr ? rd1 : fetch_i.pc;

    assign id_d.btb_hit   = fetch_i.btb_hit;
    assign id_d.is_uncond = is_jal || is_jalr;
    assign id_d.is_branch = is_branch;
    assign id_d.cmp_true  = cmp_true;
    assign id_d.pc        = fetch_i.pc;
    assign id_d.instr     = fetch_i.instr;
    assign id_d.target    = base + imm;

    // Bubble on stall or flush
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            ex_valid_q <= 1'b0;
        end else if (stall_i || flush_i) begin
            ex_valid_q <= 1'b0;
        end else begin
            ex_valid_q <= fetch_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        ex_q <= id_d;
    end

    assign ex_taken = ex_q.is_uncond || (ex_q.is_branch && ex_q.cmp_true);

    assign resolve_o.valid   = ex_valid_q;
    assign resolve_o.is_jump = ex_q.is_uncond || ex_q.is_branch;
    assign resolve_o.taken   = ex_taken;
    assign resolve_o.btb_hit = ex_q.btb_hit;
    assign resolve_o.pc      = ex_q.pc;
    assign resolve_o.target  = ex_q.target;

    assign issue_o.valid = ex_valid_q;
    assign issue_o.pc    = ex_q.pc;
    assign issue_o.instr = ex_q.instr;

endmodule

//--- reg_file.sv
`timescale 1ns/100ps

module reg_file (
    input  logic                clk_i,
    input  logic                rst_i,
    input  fetch_pkg::reg_idx_t rs1_i,
    input  fetch_pkg::reg_idx_t rs2_i,
    input  fetch_pkg::reg_wr_t  wb_i,
    output fetch_pkg::word_t    rd1_o,
    output fetch_pkg::word_t    rd2_o
);

    fetch_pkg::word_t regs_q [32];

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wb_i.en && (wb_i.addr != '0)) begin
            // x0 is never written
            regs_q[wb_i.addr] <= wb_i.data;
        end
    end

    // No write-through, a same-cycle write shows on the next read
    assign rd1_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
    assign rd2_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

endmodule

//--- fetch_buffer.sv
`timescale 1ns/100ps

module fetch_buffer (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              stall_i,
    input  logic              flush_i,
    input  fetch_pkg::fetch_t fetch_i,
    output fetch_pkg::fetch_t fetch_o
);

    logic              valid_q;
    fetch_pkg::fetch_t data_q;

    // Flush wins over stall
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (!stall_i) begin
            valid_q <= fetch_i.valid;
        end
    end

    // Payload only moves when the stage advances
    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            data_q <= fetch_i;
        end
    end

    always_comb begin
        fetch_o       = data_q;
        fetch_o.valid = valid_q;
    end

endmodule

//--- fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit #(
    parameter int BTB_INDEX_WIDTH = 6
) (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                stall_i,
    input  fetch_pkg::word_t    instr_i,
    input  fetch_pkg::resolve_t resolve_i,
    output fetch_pkg::word_t    pc_o,
    output fetch_pkg::fetch_t   fetch_o,
    output logic                flush_o
);

    fetch_pkg::word_t pc_q;
    fetch_pkg::word_t pc_plus4;
    fetch_pkg::word_t ex_pc_plus4;
    fetch_pkg::word_t next_pc;
    fetch_pkg::word_t btb_target;
    logic [1:0]       next_sel;
    logic             btb_hit;

    assign pc_plus4    = pc_q + fetch_pkg::word_t'(4);
    assign ex_pc_plus4 = resolve_i.pc + fetch_pkg::word_t'(4);

    btb_predictor #(
        .BTB_INDEX_WIDTH (BTB_INDEX_WIDTH)
    ) u_btb (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .pc_i          (pc_q),
        .resolve_i     (resolve_i),
        .ex_pc_plus4_i (ex_pc_plus4),
        .btb_hit_o     (btb_hit),
        .next_sel_o    (next_sel),
        .btb_target_o  (btb_target),
        .flush_o       (flush_o)
    );

    always_comb begin
        unique case (next_sel)
            fetch_pkg::NEXT_EX_SEQ:    next_pc = ex_pc_plus4;
            fetch_pkg::NEXT_BTB:       next_pc = btb_target;
            fetch_pkg::NEXT_EX_TARGET: next_pc = resolve_i.target;
            default:                   next_pc = pc_plus4;
        endcase
    end

    // A redirect loads even while stalled
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            pc_q <= fetch_pkg::RESET_PC;
        end else if (flush_o || !stall_i) begin
            pc_q <= next_pc;
        end
    end

    assign pc_o = pc_q;

    assign fetch_o.valid   = 1'b1;
    assign fetch_o.pc      = pc_q;
    assign fetch_o.instr   = instr_i;
    assign fetch_o.btb_hit = btb_hit;

endmodule

//--- btb_predictor.sv
`timescale 1ns/100ps

module btb_predictor #(
    parameter int BTB_INDEX_WIDTH = 6
) (
    input  logic               clk_i,
    input  logic               rst_i,
    input  fetch_pkg::word_t   pc_i,
    input  fetch_pkg::resolve_t resolve_i,
    input  fetch_pkg::word_t   ex_pc_plus4_i,
    output logic               btb_hit_o,
    output logic [1:0]         next_sel_o,
    output fetch_pkg::word_t   btb_target_o,
    output logic               flush_o
);

    localparam int TAG_WIDTH = fetch_pkg::XLEN - BTB_INDEX_WIDTH - 2;
    localparam int DEPTH     = 2 ** BTB_INDEX_WIDTH;

    logic [DEPTH-1:0]     valid_q;
    logic [TAG_WIDTH-1:0] tag_mem [DEPTH];
    fetch_pkg::word_t     target_mem [DEPTH];

    logic [BTB_INDEX_WIDTH-1:0] rd_index;
    logic [BTB_INDEX_WIDTH-1:0] wr_index;
    logic [TAG_WIDTH-1:0]       rd_tag;
    logic [TAG_WIDTH-1:0]       wr_tag;
    fetch_pkg::word_t           ex_pred_next;
    fetch_pkg::word_t           ex_actual_next;
    logic                       train;

    // Fetch side lookup
    assign rd_index = pc_i[BTB_INDEX_WIDTH+1:2];
    assign rd_tag   = pc_i[fetch_pkg::XLEN-1:BTB_INDEX_WIDTH+2];

    assign btb_hit_o    = valid_q[rd_index] && (tag_mem[rd_index] == rd_tag);
    assign btb_target_o = target_mem[rd_index];

    // EX side entry
    assign wr_index = resolve_i.pc[BTB_INDEX_WIDTH+1:2];
    assign wr_tag   = resolve_i.pc[fetch_pkg::XLEN-1:BTB_INDEX_WIDTH+2];

    // The entry cannot change between fetch and EX of the same instruction,
    // since every write comes with a flush of the younger stages
    assign ex_pred_next   = resolve_i.btb_hit ? target_mem[wr_index] : ex_pc_plus4_i;
    assign ex_actual_next = resolve_i.taken ? resolve_i.target : ex_pc_plus4_i;

    // Direction wrong, or taken to a stale target
    assign flush_o = resolve_i.valid &&
                     ((resolve_i.btb_hit != resolve_i.taken) ||
                      (ex_pred_next != ex_actual_next));

    // Always-taken: only taken jumps allocate, not-taken hits stay
    assign train = flush_o && resolve_i.is_jump && resolve_i.taken;

    always_comb begin
        if (flush_o) begin
            next_sel_o = resolve_i.taken ? fetch_pkg::NEXT_EX_TARGET
                                         : fetch_pkg::NEXT_EX_SEQ;
        end else if (btb_hit_o) begin
            next_sel_o = fetch_pkg::NEXT_BTB;
        end else begin
            next_sel_o = fetch_pkg::NEXT_SEQ;
        end
    end

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            valid_q <= '0;
        end else if (train) begin
            valid_q[wr_index] <= 1'b1;
        end
    end

    // Tag and target storage
    always_ff @(posedge clk_i) begin
        if (train) begin
            tag_mem[wr_index]    <= wr_tag;
            target_mem[wr_index] <= resolve_i.target;
        end
    end

endmodule

//--- fetch_pkg.sv
package fetch_pkg;

    // Data and address width
    localparam int XLEN = 32;

    typedef logic [4:0]      reg_idx_t;
    typedef logic [XLEN-1:0] word_t;

    localparam word_t RESET_PC = '0;

    // Control transfer opcodes
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // B-type funct3 codes
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // Next-PC select codes
    localparam logic [1:0] NEXT_SEQ       = 2'b00;
    localparam logic [1:0] NEXT_EX_SEQ    = 2'b01;
    localparam logic [1:0] NEXT_BTB       = 2'b10;
    localparam logic [1:0] NEXT_EX_TARGET = 2'b11;

    // IF/ID payload
    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
        logic  btb_hit;
    } fetch_t;

    // Branch outcome reported from EX to the predictor
    typedef struct packed {
        logic  valid;
        logic  is_jump;
        logic  taken;
        logic  btb_hit;
        word_t pc;
        word_t target;
    } resolve_t;

    // Register file write-back
    typedef struct packed {
        logic     en;
        reg_idx_t addr;
        word_t    data;
    } reg_wr_t;

    // Instruction seen in EX
    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } issue_t;

endpackage
